/* Makefile */
TOOL    = verilator
FLAGS   = --binary --timing --assert -j 0
TOP     = comms_tb
FLIST   = list.f
LOG     = sim.log
RUNARGS = +verilator+error+limit+1000

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST)

run: build
	./obj_dir/V$(TOP) $(RUNARGS) 2>&1 | tee $(LOG)
	@if grep -qF "*** TEST FAILED ***" $(LOG); then exit 1; fi
	@grep -qF "*** TEST PASSED ***" $(LOG)

lint:
	$(TOOL) --lint-only --timing -Wall --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf obj_dir $(LOG)

/* dv/comms_assert.sv */
/*
 * Bus and generator timing assertions, bound to comms_top
 */
`timescale 1ns/1ps
`default_nettype none

module comms_assert import comms_pkg::*; (
   input  wire               lb_clk,
   input  wire               reset_i,
   input  wire               lb_valid_i,
   input  wire               lb_rnw_i,
   input  wire [LB_DWI-1:0]  lb_rdata_o,
   input  wire               tx_valid_o,
   input  wire [LB_DWI-1:0]  tx_data0_o,
   input  wire [LB_DWI-1:0]  tx_data1_o,
   input  wire [4:0]         pgen_rate
);

   int fail_cnt = 0;

   // Pulses are spaced when the rate is nonzero
   tx_spacing: assert property (@(posedge lb_clk) disable iff (reset_i)
      (tx_valid_o && pgen_rate != 5'd0) |=> !tx_valid_o)
      else begin
         $error("tx_valid high on two consecutive cycles");
         fail_cnt++;
      end

   tx_inverse: assert property (@(posedge lb_clk) disable iff (reset_i)
      tx_valid_o |-> (tx_data1_o == ~tx_data0_o))
      else begin
         $error("lane 1 is not the inverse of lane 0");
         fail_cnt++;
      end

   rdata_hold: assert property (@(posedge lb_clk) disable iff (reset_i)
      !$past(lb_valid_i && lb_rnw_i) |-> $stable(lb_rdata_o))
      else begin
         $error("lb_rdata changed without a read");
         fail_cnt++;
      end

endmodule

bind comms_top comms_assert assert0 (.*);

`default_nettype wire

/* dv/comms_input.txt */
// Columns: op addr data expected, all hex
// op 0 write, 1 read, 2 wait data cycles, 3 inject lane 1 error, f end
1 00 0 51463250
1 01 0 434f4d4d
1 1f 0 deadf00d
1 0b 0 deadf00d
// Control registers, then unmapped writes
0 00 5 0
0 03 3 0
0 05 2 0
0 06 a5a51234 0
0 04 1 0
0 07 ffffffff 0
0 1f ffffffff 0
1 0a 0 12341475
// Test mode, step 2, five frames 0 3 6 9 c
0 01 1 0
0 02 0 0
2 00 12 0
0 02 1 0
2 00 a 0
1 04 0 c
1 05 0 c
1 06 0 1
1 07 0 1
1 08 0 0
1 09 0 0
1 02 0 5
1 03 0 3
// User data mode, five frames
0 04 0 0
0 02 0 0
2 00 12 0
0 02 1 0
2 00 a 0
1 04 0 a5a51234
1 05 0 a5a51234
1 07 0 1
1 02 0 a
// One injected error, one frame
3 00 0 0
0 02 0 0
2 00 2 0
0 02 1 0
2 00 a 0
1 09 0 1
1 07 0 0
1 06 0 1
1 08 0 0
1 05 0 a5a51235
// Second injected error
3 00 0 0
0 02 0 0
2 00 2 0
0 02 1 0
2 00 a 0
1 09 0 2
1 08 0 0
1 02 0 c
1 03 0 3
f 00 0 0

/* dv/comms_monitor.sv */
/*
 * Bus read checker
 * Captures the expected value of each read and compares it with
 * lb_rdata one cycle later, and tracks the location output
 */
`timescale 1ns/1ps
`default_nettype none

module comms_monitor import comms_pkg::*; (
   input  wire               lb_clk,
   input  wire               reset_i,
   input  wire               lb_valid_i,
   input  wire               lb_rnw_i,
   input  wire [LB_AWI-1:0]  lb_addr_i,
   input  wire [LB_DWI-1:0]  lb_wdata_i,
   input  wire [LB_DWI-1:0]  exp_i,
   input  wire [LB_DWI-1:0]  lb_rdata_i,
   input  wire [2:0]         tx_location_i,
   output int                err_cnt_o,
   output int                chk_cnt_o
);

   logic              pend_q;
   logic [LB_DWI-1:0] exp_q;
   logic [2:0]        exp_loc_q;

   always @(posedge lb_clk) begin
      int errs;
      errs = 0;
      if (reset_i) begin
         pend_q    <= 1'b0;
         exp_q     <= '0;
         exp_loc_q <= '0;
         err_cnt_o <= 0;
         chk_cnt_o <= 0;
      end else begin
         // Data from the read seen on the previous edge
         if (pend_q) begin
            chk_cnt_o <= chk_cnt_o + 1;
            if (lb_rdata_i !== exp_q) begin
               $display("ERR lb_rdata got %h expected %h", lb_rdata_i, exp_q);
               errs++;
            end
         end
         // Location output follows the last write to its register
         if (tx_location_i !== exp_loc_q) begin
            $display("ERR tx_location got %h expected %h", tx_location_i, exp_loc_q);
            errs++;
         end
         err_cnt_o <= err_cnt_o + errs;
         if (lb_valid_i && !lb_rnw_i &&
             lb_addr_i[LOCAL_AWI-1:0] == TX_LOCATION_WR_REG) begin
            exp_loc_q <= lb_wdata_i[2:0];
         end
         pend_q <= lb_valid_i && lb_rnw_i;
         exp_q  <= exp_i;
      end
   end

endmodule

`default_nettype wire

/* dv/comms_tb.sv */
/*
 * Comms link test testbench
 * File-driven local bus stimulus, three-cycle loopback model
 * with lane 1 error injection, and a cycle-count timeout
 */
`timescale 1ns/1ps
`default_nettype none

module comms_tb import comms_pkg::*; ();

   localparam int LOOP_DELAY = 3;
   localparam int MAX_OPS    = 64;

   logic              lb_clk;
   logic              reset_i;
   logic              lb_valid_i;
   logic              lb_rnw_i;
   logic [LB_AWI-1:0] lb_addr_i;
   logic [LB_DWI-1:0] lb_wdata_i;
   logic [LB_DWI-1:0] lb_rdata_o;
   logic              tx_valid_o;
   logic [LB_DWI-1:0] tx_data0_o;
   logic [LB_DWI-1:0] tx_data1_o;
   logic              rx_valid_i;
   logic [LB_DWI-1:0] rx_data0_i;
   logic [LB_DWI-1:0] rx_data1_i;
   logic [2:0]        tx_location_o;

   logic [LB_DWI-1:0] exp_val;
   logic [31:0]       recs [0:4*MAX_OPS-1];
   int                err_cnt;
   int                chk_cnt;
   int                stim_errs;
   int                cycle_cnt;
   int                cycle_limit;
   int                inject_req;
   int                inject_done;

   // Loopback pipeline
   logic              pipe_valid [LOOP_DELAY];
   logic [LB_DWI-1:0] pipe_d0 [LOOP_DELAY];
   logic [LB_DWI-1:0] pipe_d1 [LOOP_DELAY];

   comms_top dut0 (.*);

   comms_monitor mon0 (
      .lb_clk, .reset_i, .lb_valid_i, .lb_rnw_i, .lb_addr_i, .lb_wdata_i, .exp_i(exp_val),
      .lb_rdata_i(lb_rdata_o), .tx_location_i(tx_location_o),
      .err_cnt_o(err_cnt), .chk_cnt_o(chk_cnt)
   );

   initial begin
      lb_clk = 1'b0;
      forever #10 lb_clk = ~lb_clk;
   end

   // ------------------------------------------------------------------------
   // Loopback, captured at the edge and driven 1 ns later
   // ------------------------------------------------------------------------
   always @(posedge lb_clk) begin
      if (reset_i) begin
         inject_done <= 0;
         for (int i = 0; i < LOOP_DELAY; i++) begin
            pipe_valid[i] <= 1'b0;
            pipe_d0[i]    <= '0;
            pipe_d1[i]    <= '0;
         end
      end else begin
         pipe_valid[0] <= tx_valid_o;
         pipe_d0[0]    <= tx_data0_o;
         // Pending injection hits the next lane 1 word only
         if (tx_valid_o && inject_req != inject_done) begin
            pipe_d1[0]  <= tx_data1_o ^ 32'h1;
            inject_done <= inject_done + 1;
         end else begin
            pipe_d1[0] <= tx_data1_o;
         end
         for (int i = 1; i < LOOP_DELAY; i++) begin
            pipe_valid[i] <= pipe_valid[i-1];
            pipe_d0[i]    <= pipe_d0[i-1];
            pipe_d1[i]    <= pipe_d1[i-1];
         end
      end
   end

   always @(posedge lb_clk) begin
      #1;
      rx_valid_i = pipe_valid[LOOP_DELAY-1];
      rx_data0_i = pipe_d0[LOOP_DELAY-1];
      rx_data1_i = pipe_d1[LOOP_DELAY-1];
   end

   // Timeout
   always @(posedge lb_clk) begin
      cycle_cnt = cycle_cnt + 1;
      if (cycle_cnt > cycle_limit) begin
         $display("Timeout after %0d cycles, stimulus never finished", cycle_cnt);
         $display("*** TEST FAILED ***");
         $finish;
      end
   end

   // ------------------------------------------------------------------------
   // Stimulus, ops 0 write, 1 read, 2 wait, 3 inject, f end
   // ------------------------------------------------------------------------
   initial begin
      int n;
      int total;
      logic [31:0] op;
      logic [31:0] data;
      lb_valid_i  = 1'b0;
      lb_rnw_i    = 1'b0;
      lb_addr_i   = '0;
      lb_wdata_i  = '0;
      rx_valid_i  = 1'b0;
      rx_data0_i  = '0;
      rx_data1_i  = '0;
      reset_i     = 1'b1;
      exp_val     = '0;
      stim_errs   = 0;
      cycle_cnt   = 0;
      inject_req  = 0;
      cycle_limit = 1000000;
      $readmemh("dv/comms_input.txt", recs);
      total = 0;
      for (int i = 0; i < MAX_OPS && recs[4*i] !== 32'hf; i++) begin
         total += (recs[4*i] == 32'h2) ? recs[4*i+2] : 1;
      end
      cycle_limit = total + 10 + 50;
      repeat (10) @(posedge lb_clk);
      #1;
      reset_i = 1'b0;
      n = 0;
      while (n < MAX_OPS && recs[4*n] !== 32'hf) begin
         op         = recs[4*n];
         data       = recs[4*n+2];
         lb_addr_i  = recs[4*n+1][LB_AWI-1:0];
         lb_wdata_i = data;
         case (op)
            32'h0: begin
               lb_valid_i = 1'b1;
               lb_rnw_i   = 1'b0;
               @(posedge lb_clk);
            end
            32'h1: begin
               lb_valid_i = 1'b1;
               lb_rnw_i   = 1'b1;
               exp_val    = recs[4*n+3];
               @(posedge lb_clk);
            end
            32'h2: begin
               lb_valid_i = 1'b0;
               repeat (data) @(posedge lb_clk);
            end
            32'h3: begin
               lb_valid_i = 1'b0;
               inject_req = inject_req + 1;
               @(posedge lb_clk);
            end
            default: begin
               $display("Unknown operation %h on line %0d of the stimulus file", op, n);
               stim_errs++;
               @(posedge lb_clk);
            end
         endcase
         #1;
         n++;
      end
      lb_valid_i = 1'b0;
      repeat (3) @(posedge lb_clk);
      if (chk_cnt == 0) begin
         $display("No bus reads were checked");
         stim_errs++;
      end
      $display("Checks %0d, value errors %0d, assertion errors %0d, other errors %0d",
               chk_cnt, err_cnt, dut0.assert0.fail_cnt, stim_errs);
      if (err_cnt == 0 && stim_errs == 0 && dut0.assert0.fail_cnt == 0) begin
         $display("*** TEST PASSED ***");
      end else begin
         $display("*** TEST FAILED ***");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* hw/comms_lane_check.sv */
/*
 * Lane checker
 * Compares each received word with the pattern rule and keeps the
 * last word, a match flag and a saturating error count
 */
`timescale 1ns/1ps
`default_nettype none

module comms_lane_check import comms_pkg::*; (
   input  wire                lb_clk,
   input  wire                reset_i,
   input  wire                rx_valid_i,
   input  wire [LB_DWI-1:0]   rx_data_i,
   input  wire                invert_i,
   input  wire                test_mode_i,
   input  wire [2:0]          inc_step_i,
   input  wire [LB_DWI-1:0]   usr_data_i,
   output logic [LB_DWI-1:0]  rx_data_o,
   output logic               rx_match_o,
   output logic [15:0]        rx_err_cnt_o
);

   logic [LB_DWI-1:0] word;
   logic [LB_DWI-1:0] expected;
   logic              seen_q;
   logic              hit;

   // Lane 1 arrives inverted
   assign word = invert_i ? ~rx_data_i : rx_data_i;

   assign expected = test_mode_i ? rx_data_o + LB_DWI'(inc_step_i) + LB_DWI'(1)
                                 : usr_data_i;

   // Nothing to predict from before the first frame
   assign hit = (word == expected) || (test_mode_i && !seen_q);

   always_ff @(posedge lb_clk) begin
      if (reset_i) begin
         rx_data_o    <= '0;
         rx_match_o   <= 1'b0;
         rx_err_cnt_o <= '0;
         seen_q       <= 1'b0;
      end else if (rx_valid_i) begin
         rx_data_o  <= word;
         rx_match_o <= hit;
         seen_q     <= 1'b1;
         if (!hit && rx_err_cnt_o != ERR_CNT_MAX) begin
            rx_err_cnt_o <= rx_err_cnt_o + 16'd1;
         end
      end
   end

endmodule

`default_nettype wire

/* hw/comms_pgen.sv */
/*
 * Pattern generator
 * Emits one word every rate+1 cycles while enabled, either a
 * stepping count or the user word, with lane 1 inverted
 */
`timescale 1ns/1ps
`default_nettype none

module comms_pgen import comms_pkg::*; (
   input  wire                lb_clk,
   input  wire                reset_i,
   input  wire                enable_i,
   input  wire [4:0]          rate_i,
   input  wire                test_mode_i,
   input  wire [2:0]          inc_step_i,
   input  wire [LB_DWI-1:0]   usr_data_i,
   output logic               tx_valid_o,
   output logic [LB_DWI-1:0]  tx_data0_o,
   output logic [LB_DWI-1:0]  tx_data1_o
);

   logic [4:0]        pace_q;
   logic [LB_DWI-1:0] next_word_q;
   logic [LB_DWI-1:0] word;
   logic              fire;

   // Word going out on this pulse
   assign word = test_mode_i ? next_word_q : usr_data_i;
   assign fire = enable_i && (pace_q == '0);

   // Pacing counter, reloads with the rate on each pulse
   always_ff @(posedge lb_clk) begin
      if (reset_i) begin
         pace_q      <= '0;
         tx_valid_o  <= 1'b0;
         next_word_q <= '0;
      end else if (!enable_i) begin
         pace_q     <= '0;
         tx_valid_o <= 1'b0;
      end else if (fire) begin
         pace_q     <= rate_i;
         tx_valid_o <= 1'b1;
         // Next count follows whatever word was just sent
         next_word_q <= word + LB_DWI'(inc_step_i) + LB_DWI'(1);
      end else begin
         pace_q     <= pace_q - 5'd1;
         tx_valid_o <= 1'b0;
      end
   end

   // Payload only moves on a pulse, both lanes loaded together
   always_ff @(posedge lb_clk) begin
      if (fire) begin
         tx_data0_o <= word;
         tx_data1_o <= ~word;
      end
   end

endmodule

`default_nettype wire

/* hw/comms_pkg.sv */
/*
 * Comms link test shared definitions
 * Local bus widths, register address map, identification words
 * and error counter limits
 */
`default_nettype none

package comms_pkg;

   // ------------------------------------------------------------------------
   // Local bus geometry
   // ------------------------------------------------------------------------
   localparam int LB_AWI    = 24;
   localparam int LB_DWI    = 32;
   localparam int LOCAL_AWI = 5;

   // Read address map
   localparam logic [LOCAL_AWI-1:0] INFO0_RD_REG            = 5'd0;
   localparam logic [LOCAL_AWI-1:0] INFO1_RD_REG            = 5'd1;
   localparam logic [LOCAL_AWI-1:0] RX_FRAME_COUNTER_RD_REG = 5'd2;
   localparam logic [LOCAL_AWI-1:0] TXRX_LATENCY_RD_REG     = 5'd3;
   localparam logic [LOCAL_AWI-1:0] RX_DATA0_RD_REG         = 5'd4;
   localparam logic [LOCAL_AWI-1:0] RX_DATA1_RD_REG         = 5'd5;
   localparam logic [LOCAL_AWI-1:0] RX_MATCH0_RD_REG        = 5'd6;
   localparam logic [LOCAL_AWI-1:0] RX_MATCH1_RD_REG        = 5'd7;
   localparam logic [LOCAL_AWI-1:0] RX_ERR_CNT0_RD_REG      = 5'd8;
   localparam logic [LOCAL_AWI-1:0] RX_ERR_CNT1_RD_REG      = 5'd9;
   localparam logic [LOCAL_AWI-1:0] CTRL_READBACK_RD_REG    = 5'd10;

   // Write address map
   localparam logic [LOCAL_AWI-1:0] TX_LOCATION_WR_REG    = 5'd0;
   localparam logic [LOCAL_AWI-1:0] TX_TRANSMIT_EN_WR_REG = 5'd1;
   localparam logic [LOCAL_AWI-1:0] PGEN_DISABLE_WR_REG   = 5'd2;
   localparam logic [LOCAL_AWI-1:0] PGEN_RATE_WR_REG      = 5'd3;
   localparam logic [LOCAL_AWI-1:0] PGEN_TEST_MODE_WR_REG = 5'd4;
   localparam logic [LOCAL_AWI-1:0] PGEN_INC_STEP_WR_REG  = 5'd5;
   localparam logic [LOCAL_AWI-1:0] PGEN_USR_DAT_WR_REG   = 5'd6;

   // ------------------------------------------------------------------------
   // Constant read values
   // ------------------------------------------------------------------------
   // ASCII "QF2P" and "COMM"
   localparam logic [LB_DWI-1:0] INFO0_WORD    = 32'h51463250;
   localparam logic [LB_DWI-1:0] INFO1_WORD    = 32'h434f4d4d;
   localparam logic [LB_DWI-1:0] BAD_ADDR_WORD = 32'hdeadf00d;

   // Error counters stop here
   localparam logic [15:0] ERR_CNT_MAX = 16'hffff;

endpackage

`default_nettype wire

/* hw/comms_regbank.sv */
/*
 * Comms register bank
 * Decodes the local bus, holds the generator control settings
 * and returns status words one cycle after a read
 */
`timescale 1ns/1ps
`default_nettype none

module comms_regbank import comms_pkg::*; (
   input  wire                lb_clk,
   input  wire                reset_i,
   // Local bus
   input  wire                lb_valid_i,
   input  wire                lb_rnw_i,
   input  wire [LB_AWI-1:0]   lb_addr_i,
   input  wire [LB_DWI-1:0]   lb_wdata_i,
   output logic [LB_DWI-1:0]  lb_rdata_o,
   // Status in
   input  wire [15:0]         rx_frame_counter_i,
   input  wire [15:0]         txrx_latency_i,
   input  wire [LB_DWI-1:0]   rx_data0_i,
   input  wire [LB_DWI-1:0]   rx_data1_i,
   input  wire                rx_match0_i,
   input  wire                rx_match1_i,
   input  wire [15:0]         rx_err_cnt0_i,
   input  wire [15:0]         rx_err_cnt1_i,
   // Control out
   output logic [2:0]         tx_location_o,
   output logic               tx_transmit_en_o,
   output logic               pgen_disable_o,
   output logic [4:0]         pgen_rate_o,
   output logic               pgen_test_mode_o,
   output logic [2:0]         pgen_inc_step_o,
   output logic [31:0]        pgen_usr_data_o
);

   logic [LOCAL_AWI-1:0] addr;
   logic [LB_DWI-1:0]    ctrl_word;

   assign addr = lb_addr_i[LOCAL_AWI-1:0];

   // Readback layout: [2:0] location, [3] transmit enable, [4] disable,
   // [9:5] rate, [10] test mode, [13:11] step, [31:16] low half of user word
   assign ctrl_word = {pgen_usr_data_o[15:0], 2'b00, pgen_inc_step_o,
                       pgen_test_mode_o, pgen_rate_o, pgen_disable_o,
                       tx_transmit_en_o, tx_location_o};

   // ------------------------------------------------------------------------
   // Control register writes
   // ------------------------------------------------------------------------
   always_ff @(posedge lb_clk) begin
      if (reset_i) begin
         tx_location_o    <= '0;
         tx_transmit_en_o <= 1'b0;
         pgen_disable_o   <= 1'b1;
         pgen_rate_o      <= '0;
         pgen_test_mode_o <= 1'b0;
         pgen_inc_step_o  <= '0;
         pgen_usr_data_o  <= '0;
      end else if (lb_valid_i && !lb_rnw_i) begin
         case (addr)
            TX_LOCATION_WR_REG:    tx_location_o    <= lb_wdata_i[2:0];
            TX_TRANSMIT_EN_WR_REG: tx_transmit_en_o <= lb_wdata_i[0];
            PGEN_DISABLE_WR_REG:   pgen_disable_o   <= lb_wdata_i[0];
            PGEN_RATE_WR_REG:      pgen_rate_o      <= lb_wdata_i[4:0];
            PGEN_TEST_MODE_WR_REG: pgen_test_mode_o <= lb_wdata_i[0];
            PGEN_INC_STEP_WR_REG:  pgen_inc_step_o  <= lb_wdata_i[2:0];
            PGEN_USR_DAT_WR_REG:   pgen_usr_data_o  <= lb_wdata_i[31:0];
            // Unmapped writes fall through
            default: ;
         endcase
      end
   end

   // ------------------------------------------------------------------------
   // Read multiplexer, registered
   // ------------------------------------------------------------------------
   always_ff @(posedge lb_clk) begin
      if (reset_i) begin
         lb_rdata_o <= '0;
      end else if (lb_valid_i && lb_rnw_i) begin
         case (addr)
            INFO0_RD_REG:            lb_rdata_o <= INFO0_WORD;
            INFO1_RD_REG:            lb_rdata_o <= INFO1_WORD;
            RX_FRAME_COUNTER_RD_REG: lb_rdata_o <= LB_DWI'(rx_frame_counter_i);
            TXRX_LATENCY_RD_REG:     lb_rdata_o <= LB_DWI'(txrx_latency_i);
            RX_DATA0_RD_REG:         lb_rdata_o <= rx_data0_i;
            RX_DATA1_RD_REG:         lb_rdata_o <= rx_data1_i;
            RX_MATCH0_RD_REG:        lb_rdata_o <= LB_DWI'(rx_match0_i);
            RX_MATCH1_RD_REG:        lb_rdata_o <= LB_DWI'(rx_match1_i);
            RX_ERR_CNT0_RD_REG:      lb_rdata_o <= LB_DWI'(rx_err_cnt0_i);
            RX_ERR_CNT1_RD_REG:      lb_rdata_o <= LB_DWI'(rx_err_cnt1_i);
            CTRL_READBACK_RD_REG:    lb_rdata_o <= ctrl_word;
            default:                 lb_rdata_o <= BAD_ADDR_WORD;
         endcase
      end
   end

endmodule

`default_nettype wire

/* hw/comms_top.sv */
/*
 * Comms link test top level
 * Register bank, pattern generator, two lane checkers, received
 * frame counter and transmit-to-receive latency timer
 */
`timescale 1ns/1ps
`default_nettype none

module comms_top import comms_pkg::*; (
   input  wire                lb_clk,
   input  wire                reset_i,
   input  wire                lb_valid_i,
   input  wire                lb_rnw_i,
   input  wire [LB_AWI-1:0]   lb_addr_i,
   input  wire [LB_DWI-1:0]   lb_wdata_i,
   output logic [LB_DWI-1:0]  lb_rdata_o,
   output logic               tx_valid_o,
   output logic [LB_DWI-1:0]  tx_data0_o,
   output logic [LB_DWI-1:0]  tx_data1_o,
   input  wire                rx_valid_i,
   input  wire [LB_DWI-1:0]   rx_data0_i,
   input  wire [LB_DWI-1:0]   rx_data1_i,
   output logic [2:0]         tx_location_o
);

   logic              tx_transmit_en, pgen_disable, pgen_test_mode;
   logic [4:0]        pgen_rate;
   logic [2:0]        pgen_inc_step;
   logic [31:0]       pgen_usr_data;
   logic [LB_DWI-1:0] rx_data0, rx_data1;
   logic              rx_match0, rx_match1;
   logic [15:0]       rx_err_cnt0, rx_err_cnt1;
   logic [15:0]       rx_frame_counter, txrx_latency, lat_cnt_q;
   logic              lat_run_q;

   comms_regbank regbank0 (
      .lb_clk, .reset_i, .lb_valid_i, .lb_rnw_i, .lb_addr_i, .lb_wdata_i, .lb_rdata_o,
      .rx_frame_counter_i(rx_frame_counter), .txrx_latency_i(txrx_latency),
      .rx_data0_i(rx_data0), .rx_data1_i(rx_data1),
      .rx_match0_i(rx_match0), .rx_match1_i(rx_match1),
      .rx_err_cnt0_i(rx_err_cnt0), .rx_err_cnt1_i(rx_err_cnt1),
      .tx_location_o, .tx_transmit_en_o(tx_transmit_en), .pgen_disable_o(pgen_disable),
      .pgen_rate_o(pgen_rate), .pgen_test_mode_o(pgen_test_mode),
      .pgen_inc_step_o(pgen_inc_step), .pgen_usr_data_o(pgen_usr_data)
   );

   comms_pgen pgen0 (
      .lb_clk, .reset_i, .enable_i(tx_transmit_en && !pgen_disable),
      .rate_i(pgen_rate), .test_mode_i(pgen_test_mode), .inc_step_i(pgen_inc_step),
      .usr_data_i(pgen_usr_data), .tx_valid_o, .tx_data0_o, .tx_data1_o
   );

   // Lane 0 straight, lane 1 inverted
   comms_lane_check check0 (
      .lb_clk, .reset_i, .rx_valid_i, .rx_data_i(rx_data0_i), .invert_i(1'b0),
      .test_mode_i(pgen_test_mode), .inc_step_i(pgen_inc_step), .usr_data_i(pgen_usr_data),
      .rx_data_o(rx_data0), .rx_match_o(rx_match0), .rx_err_cnt_o(rx_err_cnt0)
   );

   comms_lane_check check1 (
      .lb_clk, .reset_i, .rx_valid_i, .rx_data_i(rx_data1_i), .invert_i(1'b1),
      .test_mode_i(pgen_test_mode), .inc_step_i(pgen_inc_step), .usr_data_i(pgen_usr_data),
      .rx_data_o(rx_data1), .rx_match_o(rx_match1), .rx_err_cnt_o(rx_err_cnt1)
   );

   // ------------------------------------------------------------------------
   // Frame counter and latency timer
   // ------------------------------------------------------------------------
   always_ff @(posedge lb_clk) begin
      if (reset_i) begin
         rx_frame_counter <= '0;
         txrx_latency     <= '0;
         lat_cnt_q        <= '0;
         lat_run_q        <= 1'b0;
      end else begin
         if (rx_valid_i) rx_frame_counter <= rx_frame_counter + 16'd1;
         if (lat_run_q && rx_valid_i) txrx_latency <= lat_cnt_q;
         // A new measurement only starts once the previous one has closed
         if (tx_valid_o && (!lat_run_q || rx_valid_i)) begin
            lat_run_q <= 1'b1;
            lat_cnt_q <= 16'd1;
         end else if (lat_run_q && rx_valid_i) begin
            lat_run_q <= 1'b0;
         end else if (lat_run_q && lat_cnt_q != 16'hffff) begin
            lat_cnt_q <= lat_cnt_q + 16'd1;
         end
      end
   end

endmodule

`default_nettype wire

/* list.f */
hw/comms_pkg.sv
hw/comms_regbank.sv
hw/comms_pgen.sv
hw/comms_lane_check.sv
hw/comms_top.sv
dv/comms_assert.sv
dv/comms_monitor.sv
dv/comms_tb.sv
